//--- axi_adapter_pkg.sv
/*
 * AXI adapter package
 * Bus widths, AXI4 channel payloads and the request and engine state
 * types shared by the cache-side adapter and its read and write engines.
 */
package axi_adapter_pkg;

  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned WordWidth  = 64;
  localparam int unsigned StrbWidth  = WordWidth / 8;
  localparam int unsigned IdWidth    = 4;
  // byte offset bits inside one data beat
  localparam int unsigned ByteOffset = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [WordWidth-1:0] word_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [IdWidth-1:0]   id_t;

  // fixed AXI field values
  localparam logic [1:0] BurstIncr       = 2'b01;
  localparam logic [3:0] CacheModifiable = 4'b0010;

  typedef enum logic {
    SINGLE_REQ,
    LINE_REQ
  } ad_req_e;

  // ------------------------------
  // AXI4 channel payloads
  // ------------------------------
  // shared by AW and AR
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic [3:0] cache;
  } axi_ax_t;

  typedef struct packed {
    word_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } axi_b_t;

  typedef struct packed {
    id_t        id;
    word_t      data;
    logic [1:0] resp;
    logic       last;
  } axi_r_t;

  typedef struct packed {
    logic    aw_valid;
    axi_ax_t aw;
    logic    w_valid;
    axi_w_t  w;
    logic    b_ready;
    logic    ar_valid;
    axi_ax_t ar;
    logic    r_ready;
  } axi_req_t;

  typedef struct packed {
    logic   aw_ready;
    logic   ar_ready;
    logic   w_ready;
    logic   b_valid;
    axi_b_t b;
    logic   r_valid;
    axi_r_t r;
  } axi_rsp_t;

  // ------------------------------
  // engine states
  // ------------------------------
  typedef enum logic [2:0] {
    W_IDLE,
    W_WAIT_AW,
    W_WAIT_LAST_W,
    W_WAIT_LAST_W_AW,
    W_WAIT_AW_BURST,
    W_WAIT_B
  } write_state_e;

  typedef enum logic [1:0] {
    R_IDLE,
    R_WAIT_SINGLE,
    R_WAIT_LINE,
    R_COMPLETE
  } read_state_e;

  // base address of the cache line holding addr
  function automatic addr_t line_base(addr_t addr, int unsigned line_words);
    addr_t mask;
    mask = ~addr_t'(line_words * StrbWidth - 1);
    return addr & mask;
  endfunction

endpackage

//--- axi_write_engine.sv
/*
 * AXI write engine
 * Issues single-beat and cache-line writes on AW and W, grants the
 * request once the address and the last data beat are accepted and
 * reports the B response back to the cache.
 */
`timescale 1ns/10ps

module axi_write_engine import axi_adapter_pkg::*; #(
  parameter int unsigned LineWords = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  ad_req_e                   type_i,
  input  addr_t                     addr_i,
  input  logic [1:0]                size_i,
  input  id_t                       id_i,
  input  word_t [LineWords-1:0]     wdata_i,
  input  strb_t [LineWords-1:0]     be_i,
  input  axi_rsp_t                  rsp_i,
  output logic                      gnt_o,
  output logic                      busy_o,
  output logic                      valid_o,
  output id_t                       id_o,
  output axi_ax_t                   aw_o,
  output logic                      aw_valid_o,
  output axi_w_t                    w_o,
  output logic                      w_valid_o,
  output logic                      b_ready_o
);

  localparam int unsigned IdxWidth = (LineWords > 1) ? $clog2(LineWords) : 1;
  localparam logic [IdxWidth-1:0] LastBeat = IdxWidth'(LineWords - 1);

  write_state_e          state_q, state_d;
  logic [IdxWidth-1:0]   beat_q, beat_d;
  logic                  is_single;
  logic                  w_last;
  logic                  w_done;

  assign is_single = (type_i == SINGLE_REQ);
  assign w_last    = is_single || (beat_q == LastBeat);
  // last data beat accepted in this cycle
  assign w_done    = rsp_i.w_ready & w_last;

  assign busy_o = (state_q != W_IDLE);
  assign id_o   = rsp_i.b.id;

  // request fields stay steady until the grant, so drive them straight through
  always_comb begin
    aw_o.id    = id_i;
    aw_o.addr  = is_single ? addr_i : line_base(addr_i, LineWords);
    aw_o.len   = is_single ? 8'd0 : 8'(LineWords - 1);
    aw_o.size  = is_single ? {1'b0, size_i} : 3'(ByteOffset);
    aw_o.burst = BurstIncr;
    aw_o.cache = CacheModifiable;

    w_o.data = wdata_i[beat_q];
    w_o.strb = be_i[beat_q];
    w_o.last = w_last;
  end

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb begin
    state_d    = state_q;
    beat_d     = beat_q;
    gnt_o      = 1'b0;
    valid_o    = 1'b0;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    b_ready_o  = 1'b0;

    case (state_q)
      // both AW and W still outstanding
      W_IDLE, W_WAIT_LAST_W_AW: begin
        if (req_i || state_q == W_WAIT_LAST_W_AW) begin
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          if (rsp_i.w_ready && !w_last) begin
            beat_d = beat_q + IdxWidth'(1);
          end
          case ({rsp_i.aw_ready, w_done})
            2'b11: begin
              gnt_o   = 1'b1;
              beat_d  = '0;
              state_d = W_WAIT_B;
            end
            2'b10: state_d = W_WAIT_LAST_W;
            2'b01: state_d = is_single ? W_WAIT_AW : W_WAIT_AW_BURST;
            default: begin
              // a middle beat went out before the address
              if (rsp_i.w_ready) begin
                state_d = W_WAIT_LAST_W_AW;
              end
            end
          endcase
        end
      end

      W_WAIT_LAST_W: begin
        w_valid_o = 1'b1;
        if (rsp_i.w_ready) begin
          if (w_last) begin
            gnt_o   = 1'b1;
            beat_d  = '0;
            state_d = W_WAIT_B;
          end else begin
            beat_d = beat_q + IdxWidth'(1);
          end
        end
      end

      // all data sent, only the address is left
      W_WAIT_AW, W_WAIT_AW_BURST: begin
        aw_valid_o = 1'b1;
        if (rsp_i.aw_ready) begin
          gnt_o   = 1'b1;
          beat_d  = '0;
          state_d = W_WAIT_B;
        end
      end

      W_WAIT_B: begin
        b_ready_o = rsp_i.b_valid;
        if (rsp_i.b_valid) begin
          valid_o = 1'b1;
          state_d = W_IDLE;
        end
      end

      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= W_IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      beat_q  <= beat_d;
    end
  end

endmodule

//--- axi_read_engine.sv
/*
 * AXI read engine
 * Issues single-beat and incremental cache-line reads on AR, collects
 * the R beats into a line buffer and flags the critical word as it
 * passes. The full line is returned one cycle after the last beat.
 */
`timescale 1ns/10ps

module axi_read_engine import axi_adapter_pkg::*; #(
  parameter int unsigned LineWords = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  ad_req_e                   type_i,
  input  addr_t                     addr_i,
  input  logic [1:0]                size_i,
  input  id_t                       id_i,
  input  axi_rsp_t                  rsp_i,
  output logic                      gnt_o,
  output logic                      busy_o,
  output logic                      valid_o,
  output word_t [LineWords-1:0]     line_o,
  output id_t                       id_o,
  output word_t                     critical_word_o,
  output logic                      critical_word_valid_o,
  output axi_ax_t                   ar_o,
  output logic                      ar_valid_o,
  output logic                      r_ready_o
);

  localparam int unsigned IdxWidth = (LineWords > 1) ? $clog2(LineWords) : 1;

  read_state_e           state_q, state_d;
  logic [IdxWidth-1:0]   beat_q, beat_d;
  word_t [LineWords-1:0] line_q, line_d;
  // word of the line that caused the miss
  logic [IdxWidth-1:0]   offset_q, offset_d;
  id_t                   id_q, id_d;
  logic                  is_single;

  assign is_single = (type_i == SINGLE_REQ);

  assign busy_o          = (state_q != R_IDLE);
  assign line_o          = line_q;
  assign id_o            = id_q;
  assign critical_word_o = rsp_i.r.data;

  // line reads start at the line base so the beats arrive in word order
  always_comb begin
    ar_o.id    = id_i;
    ar_o.addr  = is_single ? addr_i : line_base(addr_i, LineWords);
    ar_o.len   = is_single ? 8'd0 : 8'(LineWords - 1);
    ar_o.size  = is_single ? {1'b0, size_i} : 3'(ByteOffset);
    ar_o.burst = BurstIncr;
    ar_o.cache = CacheModifiable;
  end

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb begin
    state_d               = state_q;
    beat_d                = beat_q;
    line_d                = line_q;
    offset_d              = offset_q;
    id_d                  = id_q;
    gnt_o                 = 1'b0;
    valid_o               = 1'b0;
    ar_valid_o            = 1'b0;
    r_ready_o             = 1'b0;
    critical_word_valid_o = 1'b0;

    case (state_q)
      R_IDLE: begin
        if (req_i) begin
          ar_valid_o = 1'b1;
          gnt_o      = rsp_i.ar_ready;
          if (rsp_i.ar_ready) begin
            beat_d   = '0;
            offset_d = addr_i[ByteOffset +: IdxWidth];
            state_d  = is_single ? R_WAIT_SINGLE : R_WAIT_LINE;
          end
        end
      end

      R_WAIT_SINGLE, R_WAIT_LINE: begin
        r_ready_o = 1'b1;
        if (rsp_i.r_valid) begin
          if (state_q == R_WAIT_LINE) begin
            line_d[beat_q]        = rsp_i.r.data;
            critical_word_valid_o = (beat_q == offset_q);
            beat_d                = beat_q + IdxWidth'(1);
          end else begin
            line_d[0] = rsp_i.r.data;
          end
          if (rsp_i.r.last) begin
            id_d    = rsp_i.r.id;
            state_d = R_COMPLETE;
          end
        end
      end

      R_COMPLETE: begin
        valid_o = 1'b1;
        state_d = R_IDLE;
      end

      default: state_d = R_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= R_IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      beat_q  <= beat_d;
    end
  end

  // line buffer and saved request data
  always_ff @(posedge clk_i) begin
    line_q   <= line_d;
    offset_q <= offset_d;
    id_q     <= id_d;
  end

endmodule

//--- axi_adapter.sv
/*
 * Cache to AXI4 adapter
 * Steers cache requests to the write or the read engine, merges their
 * grant and response strobes and assembles the AXI master port.
 */
`timescale 1ns/10ps

module axi_adapter import axi_adapter_pkg::*; #(
  parameter int unsigned LineWords = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  output logic                      busy_o,
  input  logic                      req_i,
  input  ad_req_e                   type_i,
  output logic                      gnt_o,
  input  addr_t                     addr_i,
  input  logic                      we_i,
  input  word_t [LineWords-1:0]     wdata_i,
  input  strb_t [LineWords-1:0]     be_i,
  input  logic [1:0]                size_i,
  input  id_t                       id_i,
  output logic                      valid_o,
  output word_t [LineWords-1:0]     rdata_o,
  output id_t                       id_o,
  output word_t                     critical_word_o,
  output logic                      critical_word_valid_o,
  output axi_req_t                  axi_req_o,
  input  axi_rsp_t                  axi_resp_i
);

  logic                  wr_req, wr_gnt, wr_busy, wr_valid;
  logic                  rd_req, rd_gnt, rd_busy, rd_valid;
  id_t                   wr_id, rd_id;
  word_t [LineWords-1:0] rd_line;
  axi_ax_t               aw, ar;
  axi_w_t                w;
  logic                  aw_valid, w_valid, b_ready;
  logic                  ar_valid, r_ready;

  // a new request waits until the other engine has finished
  assign wr_req = req_i & we_i & ~rd_busy;
  assign rd_req = req_i & ~we_i & ~wr_busy;

  axi_write_engine #(
    .LineWords (LineWords)
  ) u_write (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (wr_req),
    .type_i     (type_i),
    .addr_i     (addr_i),
    .size_i     (size_i),
    .id_i       (id_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .rsp_i      (axi_resp_i),
    .gnt_o      (wr_gnt),
    .busy_o     (wr_busy),
    .valid_o    (wr_valid),
    .id_o       (wr_id),
    .aw_o       (aw),
    .aw_valid_o (aw_valid),
    .w_o        (w),
    .w_valid_o  (w_valid),
    .b_ready_o  (b_ready)
  );

  axi_read_engine #(
    .LineWords (LineWords)
  ) u_read (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (rd_req),
    .type_i                (type_i),
    .addr_i                (addr_i),
    .size_i                (size_i),
    .id_i                  (id_i),
    .rsp_i                 (axi_resp_i),
    .gnt_o                 (rd_gnt),
    .busy_o                (rd_busy),
    .valid_o               (rd_valid),
    .line_o                (rd_line),
    .id_o                  (rd_id),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o),
    .ar_o                  (ar),
    .ar_valid_o            (ar_valid),
    .r_ready_o             (r_ready)
  );

  // ------------------------------
  // cache side merge
  // ------------------------------
  assign busy_o  = wr_busy | rd_busy;
  assign gnt_o   = wr_gnt | rd_gnt;
  assign valid_o = wr_valid | rd_valid;
  assign id_o    = rd_valid ? rd_id : wr_id;
  // writes return no data
  assign rdata_o = rd_valid ? rd_line : '0;

  // write engine owns AW, W and B, read engine owns AR and R
  always_comb begin
    axi_req_o.aw_valid = aw_valid;
    axi_req_o.aw       = aw;
    axi_req_o.w_valid  = w_valid;
    axi_req_o.w        = w;
    axi_req_o.b_ready  = b_ready;
    axi_req_o.ar_valid = ar_valid;
    axi_req_o.ar       = ar;
    axi_req_o.r_ready  = r_ready;
  end

endmodule

//--- tb_axi_mem.sv
/*
 * AXI slave memory for the adapter testbench
 * 256 bytes of word memory with one outstanding read and one outstanding
 * write. Every ready and valid is held off for 0 to 3 random cycles.
 */
`timescale 1ns/10ps

module tb_axi_mem import axi_adapter_pkg::*; #(
  parameter logic [31:0] Seed = 32'h1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  axi_req_t req_i,
  output axi_rsp_t rsp_o
);

  word_t       mem [32];
  logic [31:0] rnd;
  logic [1:0]  aw_cnt, w_cnt, b_cnt, ar_cnt, r_cnt;
  logic        aw_have, w_done, b_pend, rd_active;
  addr_t       aw_addr, rd_addr;
  id_t         aw_id, rd_id;
  logic [7:0]  rd_len, rd_beat;
  axi_w_t      wbuf [8];
  logic [3:0]  w_n;

  function automatic logic [7:0] fill_byte(int unsigned a);
    return 8'(a * 29 + 23);
  endfunction

  always_comb begin
    rsp_o          = '0;
    rsp_o.aw_ready = (aw_cnt == 0) && !aw_have;
    rsp_o.w_ready  = (w_cnt == 0) && !w_done;
    rsp_o.b_valid  = b_pend && (b_cnt == 0);
    rsp_o.b.id     = aw_id;
    rsp_o.ar_ready = (ar_cnt == 0) && !rd_active;
    rsp_o.r_valid  = rd_active && (r_cnt == 0);
    rsp_o.r.id     = rd_id;
    rsp_o.r.data   = mem[rd_addr[7:3]];
    rsp_o.r.last   = (rd_beat == rd_len);
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // memory starts from its fill pattern
      for (int i = 0; i < 32; i++) begin
        for (int b = 0; b < 8; b++) begin
          mem[i][8*b +: 8] <= fill_byte(i * 8 + b);
        end
      end
      rnd       <= Seed;
      aw_cnt    <= '0;
      w_cnt     <= '0;
      b_cnt     <= '0;
      ar_cnt    <= '0;
      r_cnt     <= '0;
      aw_have   <= 1'b0;
      w_done    <= 1'b0;
      b_pend    <= 1'b0;
      rd_active <= 1'b0;
      w_n       <= '0;
      rd_beat   <= '0;
    end else begin
      rnd <= rnd ^ (rnd << 13) ^ ((rnd ^ (rnd << 13)) >> 17);
      rnd[31:5] <= rnd[31:5] ^ rnd[26:0];
      if (aw_cnt != 0) aw_cnt <= aw_cnt - 2'd1;
      if (w_cnt != 0) w_cnt <= w_cnt - 2'd1;
      if (b_cnt != 0) b_cnt <= b_cnt - 2'd1;
      if (ar_cnt != 0) ar_cnt <= ar_cnt - 2'd1;
      if (r_cnt != 0) r_cnt <= r_cnt - 2'd1;

      // ------------------------------
      // write side
      // ------------------------------
      if (req_i.aw_valid && rsp_o.aw_ready) begin
        aw_have <= 1'b1;
        aw_addr <= req_i.aw.addr;
        aw_id   <= req_i.aw.id;
        aw_cnt  <= rnd[1:0];
      end
      if (req_i.w_valid && rsp_o.w_ready) begin
        wbuf[w_n[2:0]] <= req_i.w;
        w_n            <= w_n + 4'd1;
        w_done         <= req_i.w.last;
        w_cnt          <= rnd[3:2];
      end
      // address and all data in, commit the burst
      if (aw_have && w_done && !b_pend) begin
        for (int i = 0; i < 8; i++) begin
          for (int b = 0; b < 8; b++) begin
            if (i < int'(w_n) && wbuf[i].strb[b]) begin
              mem[aw_addr[7:3] + 5'(i)][8*b +: 8] <= wbuf[i].data[8*b +: 8];
            end
          end
        end
        aw_have <= 1'b0;
        w_done  <= 1'b0;
        w_n     <= '0;
        b_pend  <= 1'b1;
        b_cnt   <= rnd[5:4];
      end
      if (rsp_o.b_valid && req_i.b_ready) begin
        b_pend <= 1'b0;
      end

      // ------------------------------
      // read side
      // ------------------------------
      if (req_i.ar_valid && rsp_o.ar_ready) begin
        rd_active <= 1'b1;
        rd_addr   <= req_i.ar.addr;
        rd_len    <= req_i.ar.len;
        rd_id     <= req_i.ar.id;
        rd_beat   <= '0;
        ar_cnt    <= rnd[7:6];
        r_cnt     <= rnd[9:8];
      end
      if (rsp_o.r_valid && req_i.r_ready) begin
        rd_addr <= rd_addr + addr_t'(8);
        rd_beat <= rd_beat + 8'd1;
        r_cnt   <= rnd[11:10];
        if (rd_beat == rd_len) begin
          rd_active <= 1'b0;
        end
      end
    end
  end

endmodule

//--- tb_axi_adapter.sv
/*
 * Testbench for the cache to AXI4 adapter
 * Random single and line requests against a stalling AXI memory,
 * checked against a byte-level reference model.
 */
`timescale 1ns/10ps

module tb_axi_adapter import axi_adapter_pkg::*; ();

  localparam int unsigned LineWords = 4;
  localparam int unsigned LineBytes = LineWords * StrbWidth;
  localparam int          Timeout   = 200;

  typedef word_t [LineWords-1:0] line_t;
  typedef strb_t [LineWords-1:0] strb_line_t;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       req_i, we_i, busy_o, gnt_o, valid_o, crit_valid;
  ad_req_e    type_i;
  addr_t      addr_i;
  line_t      wdata_i, rdata_o;
  strb_line_t be_i;
  logic [1:0] size_i;
  id_t        id_i, id_o;
  word_t      crit_word;
  axi_req_t   axi_req;
  axi_rsp_t   axi_rsp;

  logic [7:0]  model_mem [256];
  logic [31:0] rng = 32'hc3eeb974;
  int          errors = 0;
  int          checks = 0;
  // set once a wait has run out, later requests are skipped
  logic        hung = 1'b0;

  always #4 clk_i = ~clk_i;

  axi_adapter #(
    .LineWords (LineWords)
  ) u_dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .busy_o                (busy_o),
    .req_i                 (req_i),
    .type_i                (type_i),
    .gnt_o                 (gnt_o),
    .addr_i                (addr_i),
    .we_i                  (we_i),
    .wdata_i               (wdata_i),
    .be_i                  (be_i),
    .size_i                (size_i),
    .id_i                  (id_i),
    .valid_o               (valid_o),
    .rdata_o               (rdata_o),
    .id_o                  (id_o),
    .critical_word_o       (crit_word),
    .critical_word_valid_o (crit_valid),
    .axi_req_o             (axi_req),
    .axi_resp_i            (axi_rsp)
  );

  tb_axi_mem #(
    .Seed (32'h5eed1234)
  ) u_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (axi_req),
    .rsp_o  (axi_rsp)
  );

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic word_t model_word(addr_t a);
    word_t w;
    for (int b = 0; b < 8; b++) begin
      w[8*b +: 8] = model_mem[int'(a[7:0]) + b];
    end
    return w;
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_word(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_line(string name, line_t got, line_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_id(string name, id_t got, id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_len(string name, logic [7:0] got, logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic expect_true(string what, logic cond);
    checks++;
    if (cond !== 1'b1) begin
      errors++;
      $display("check failed: %s", what);
    end
  endtask

  task automatic timed_out(string what);
    errors++;
    hung = 1'b1;
    $display("timeout after %0d cycles waiting for %s", Timeout, what);
  endtask

  // one request from drive to response, with all its checks
  task automatic run_req(logic we, ad_req_e kind, addr_t addr, id_t rid,
                         line_t wd, strb_line_t wb);
    int         cycles;
    int         last_at;
    int         crit_n;
    addr_t      base;
    addr_t      ar_addr;
    logic [7:0] ar_len;
    line_t      exp_line;
    addr_t      wa;
    if (hung) return;
    base = addr & ~addr_t'(LineBytes - 1);
    @(posedge clk_i);
    #1;
    req_i   = 1'b1;
    we_i    = we;
    type_i  = kind;
    addr_i  = addr;
    id_i    = rid;
    wdata_i = wd;
    be_i    = wb;
    cycles  = 0;
    forever begin
      @(negedge clk_i);
      if (gnt_o) break;
      cycles++;
      if (cycles >= Timeout) begin
        timed_out("gnt_o");
        return;
      end
    end
    ar_addr = axi_req.ar.addr;
    ar_len  = axi_req.ar.len;
    // the model takes the write at its grant
    if (we) begin
      for (int i = 0; i < ((kind == SINGLE_REQ) ? 1 : int'(LineWords)); i++) begin
        wa = (kind == SINGLE_REQ) ? addr : base + addr_t'(i * 8);
        for (int b = 0; b < 8; b++) begin
          if (wb[i][b]) model_mem[int'(wa[7:0]) + b] = wd[i][8*b +: 8];
        end
      end
    end
    @(posedge clk_i);
    #1;
    req_i   = 1'b0;
    cycles  = 0;
    last_at = -2;
    crit_n  = 0;
    forever begin
      @(negedge clk_i);
      if (axi_req.r_ready && axi_rsp.r_valid && axi_rsp.r.last) last_at = cycles;
      if (crit_valid) begin
        crit_n++;
        check_word("critical_word_o", crit_word, model_word(addr));
      end
      if (valid_o) break;
      cycles++;
      if (cycles >= Timeout) begin
        timed_out("valid_o");
        return;
      end
    end
    check_id("id_o", id_o, rid);
    if (!we) begin
      if (kind == SINGLE_REQ) begin
        check_word("rdata_o[0]", rdata_o[0], model_word(addr));
      end else begin
        for (int i = 0; i < int'(LineWords); i++) begin
          exp_line[i] = model_word(base + addr_t'(i * 8));
        end
        check_line("rdata_o", rdata_o, exp_line);
        check_addr("axi_req_o.ar.addr", ar_addr, base);
        check_len("axi_req_o.ar.len", ar_len, 8'(LineWords - 1));
        expect_true("critical word strobe did not fire exactly once", crit_n == 1);
      end
      expect_true("read valid_o not one cycle after the last R beat",
                  last_at == cycles - 1);
    end
    @(negedge clk_i);
    expect_true("busy_o still high in the cycle after valid_o", busy_o == 1'b0);
  endtask

  task automatic random_data(output line_t wd, output strb_line_t wb);
    for (int i = 0; i < int'(LineWords); i++) begin
      wd[i] = {next_rand(), next_rand()};
      wb[i] = strb_t'(next_rand());
    end
  endtask

  task automatic report(string name, int err_before);
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "fail");
  endtask

  initial begin
    int          err0;
    logic [31:0] r;
    line_t       wd;
    strb_line_t  wb;
    addr_t       a;
    for (int i = 0; i < 256; i++) begin
      model_mem[i] = 8'(i * 29 + 23);
    end
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    type_i  = SINGLE_REQ;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    size_i  = 2'b11;
    id_i    = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    err0 = errors;
    @(negedge clk_i);
    expect_true("busy_o high after reset", !busy_o);
    expect_true("gnt_o high after reset", !gnt_o);
    expect_true("valid_o high after reset", !valid_o);
    expect_true("critical_word_valid_o high after reset", !crit_valid);
    expect_true("an AXI valid is high after reset",
                !(axi_req.aw_valid | axi_req.w_valid | axi_req.ar_valid | axi_req.b_ready));
    report("reset", err0);

    err0 = errors;
    repeat (8) begin
      r = next_rand();
      a = {24'b0, r[7:3], 3'b0};
      random_data(wd, wb);
      run_req(1'b1, SINGLE_REQ, a, id_t'(r[11:8]), wd, wb);
      run_req(1'b0, SINGLE_REQ, a, id_t'(r[15:12]), wd, wb);
    end
    report("single write and read", err0);

    err0 = errors;
    repeat (4) begin
      r = next_rand();
      a = {24'b0, r[7:5], 5'b0};
      random_data(wd, wb);
      run_req(1'b1, LINE_REQ, a, id_t'(r[11:8]), wd, wb);
      run_req(1'b0, LINE_REQ, a, id_t'(r[15:12]), wd, wb);
    end
    report("line write and read", err0);

    err0 = errors;
    for (int off = 0; off < int'(LineWords); off++) begin
      r = next_rand();
      a = {24'b0, r[7:5], 5'b0} + addr_t'(off * 8);
      run_req(1'b0, LINE_REQ, a, id_t'(r[11:8]), wd, wb);
    end
    report("critical word", err0);

    err0 = errors;
    repeat (200) begin
      r = next_rand();
      a = {24'b0, r[7:3], 3'b0};
      random_data(wd, wb);
      run_req(r[8], r[9] ? LINE_REQ : SINGLE_REQ, a, id_t'(r[15:12]), wd, wb);
    end
    report("random back-pressure", err0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
axi_adapter_pkg.sv
axi_write_engine.sv
axi_read_engine.sv
axi_adapter.sv
tb_axi_mem.sv
tb_axi_adapter.sv

//--- run.sh
#!/bin/sh
# compile and run the adapter testbench with Verilator

verilator --binary -f sim.f --top-module tb_axi_adapter -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error"
  exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi

echo "simulation passed"
exit 0
